// File: efpga_harness_pkg.sv
package efpga_harness_pkg;

   localparam int WORD_W = 32;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [19:0]       lint_addr_t;   // byte address
   typedef logic [11:0]       ram_addr_t;    // word address inside one RAM
   typedef logic [3:0]        be_t;

   typedef enum logic [1:0] {
      LINT_IDLE,
      LINT_WRITE,
      LINT_READ,
      LINT_READ_WAIT
   } lint_state_e;

   // window number is lint address bits 19:12
   typedef enum logic [1:0] {
      RAM_NONE  = 2'd0,
      RAM_OPER0 = 2'd1,
      RAM_OPER1 = 2'd2,
      RAM_COEF  = 2'd3
   } ram_sel_e;

   localparam int FPGAIO_W = 80;
   localparam int EVENTS_W = 16;
   localparam int IO_HI_W  = FPGAIO_W - 2 * WORD_W;   // width of the top I/O word

   localparam lint_addr_t ADDR_MAC0_CTRL   = 20'h00010;
   localparam lint_addr_t ADDR_MAC1_CTRL   = 20'h00014;
   localparam lint_addr_t ADDR_RAM_CTRL    = 20'h00020;
   localparam lint_addr_t ADDR_MAC0_STROBE = 20'h00030;
   localparam lint_addr_t ADDR_MAC1_STROBE = 20'h00034;
   localparam lint_addr_t ADDR_IO_OUT0     = 20'h00040;
   localparam lint_addr_t ADDR_IO_OUT1     = 20'h00044;
   localparam lint_addr_t ADDR_IO_OUT2     = 20'h00048;
   localparam lint_addr_t ADDR_IO_OE0      = 20'h00050;
   localparam lint_addr_t ADDR_IO_OE1      = 20'h00054;
   localparam lint_addr_t ADDR_IO_OE2      = 20'h00058;
   localparam lint_addr_t ADDR_IO_IN0      = 20'h00060;
   localparam lint_addr_t ADDR_IO_IN1      = 20'h00064;
   localparam lint_addr_t ADDR_IO_IN2      = 20'h00068;
   localparam lint_addr_t ADDR_EVENTS      = 20'h0006C;
   localparam lint_addr_t ADDR_MAC0_DOUT   = 20'h00100;
   localparam lint_addr_t ADDR_MAC1_DOUT   = 20'h00104;
   localparam lint_addr_t ADDR_ID          = 20'h00800;

   localparam int MAC_OUTSEL_LSB = 0;   // 6 bits
   localparam int MAC_TC_BIT     = 6;
   localparam int MAC_MODE_LSB   = 12;  // 2 bits
   localparam int MAC_OSEL_BIT   = 14;
   localparam int MAC_CSEL_BIT   = 15;
   localparam int MAC_RND_BIT    = 16;
   localparam int MAC_CLR_BIT    = 17;
   localparam int MAC_SAT_BIT    = 18;
   localparam int MAC_RESET_BIT  = 31;

   localparam int RAM_OPER0_RMODE_LSB = 0;
   localparam int RAM_OPER0_WMODE_LSB = 2;
   localparam int RAM_OPER1_RMODE_LSB = 4;
   localparam int RAM_OPER1_WMODE_LSB = 6;
   localparam int RAM_COEF_RMODE_LSB  = 8;
   localparam int RAM_COEF_WMODE_LSB  = 10;
   localparam int RAM_OPER0_WDSEL_BIT = 12;
   localparam int RAM_OPER1_WDSEL_BIT = 13;
   localparam int RAM_COEF_WDSEL_BIT  = 14;

   localparam word_t RDATA_RESET = 32'hFFFF_FFFF;

endpackage

// File: lint_slave.sv
module lint_slave (
   input  logic                          CLK,
   input  logic                          rst_n,
   input  logic                          lint_req,
   input  logic                          lint_wen,       // low means write
   input  efpga_harness_pkg::lint_addr_t lint_addr,
   input  efpga_harness_pkg::word_t      lint_wdata,
   output logic                          lint_gnt,
   output logic                          lint_valid,
   output efpga_harness_pkg::word_t      lint_rdata,
   output efpga_harness_pkg::lint_addr_t bus_addr,
   output efpga_harness_pkg::word_t      bus_wdata,
   output logic                          wr_en,
   output logic                          rd_start,
   input  efpga_harness_pkg::word_t      reg_rdata,
   input  logic                          reg_hit,
   input  efpga_harness_pkg::word_t      ram_rdata,
   input  logic                          ram_hit
);
   import efpga_harness_pkg::*;

   lint_state_e state;
   logic        accept;

   // master holds the request until it sees gnt
   assign bus_addr  = lint_addr;
   assign bus_wdata = lint_wdata;

   assign accept   = (state == LINT_IDLE) && lint_req && !lint_gnt;
   assign rd_start = accept && lint_wen;
   assign wr_en    = (state == LINT_WRITE);   // commits at the end of this cycle

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         state      <= LINT_IDLE;
         lint_gnt   <= 1'b0;
         lint_valid <= 1'b0;
         lint_rdata <= RDATA_RESET;
      end else begin
         lint_valid <= lint_gnt;   // response one cycle after gnt
         case (state)
            LINT_IDLE: begin
               lint_gnt <= 1'b0;
               if (accept) begin
                  if (!lint_wen) begin
                     lint_gnt <= 1'b1;
                     state    <= LINT_WRITE;
                  end else begin
                     state <= LINT_READ;
                  end
               end
            end
            LINT_WRITE: begin
               lint_gnt <= 1'b0;
               state    <= LINT_IDLE;
            end
            LINT_READ: begin
               if (reg_hit) begin
                  lint_rdata <= reg_rdata;
               end
               state <= LINT_READ_WAIT;
            end
            LINT_READ_WAIT: begin
               // RAM data arrives one cycle after raddr
               if (ram_hit) begin
                  lint_rdata <= ram_rdata;
               end
               lint_gnt <= 1'b1;
               state    <= LINT_IDLE;
            end
            default: begin
               lint_gnt <= 1'b0;
               state    <= LINT_IDLE;
            end
         endcase
      end
   end

endmodule

// File: harness_regs.sv
module harness_regs #(
   parameter efpga_harness_pkg::word_t ID_CODE = '0
) (
   input  logic                                  CLK,
   input  logic                                  rst_n,
   input  efpga_harness_pkg::lint_addr_t         bus_addr,
   input  efpga_harness_pkg::word_t              bus_wdata,
   input  logic                                  wr_en,
   input  logic [efpga_harness_pkg::FPGAIO_W-1:0] fpgaio_in,
   input  efpga_harness_pkg::word_t              mac0_dataout,
   input  efpga_harness_pkg::word_t              mac1_dataout,
   output efpga_harness_pkg::word_t              reg_rdata,
   output logic                                  reg_hit,
   output logic [5:0]                            mac0_outsel,
   output logic                                  mac0_tc,
   output logic [1:0]                            mac0_mode,
   output logic                                  mac0_osel, mac0_csel,
   output logic                                  mac0_rnd, mac0_clr, mac0_sat,
   output logic                                  mac0_reset,
   output logic                                  mac0_clken,
   output logic [5:0]                            mac1_outsel,
   output logic                                  mac1_tc,
   output logic [1:0]                            mac1_mode,
   output logic                                  mac1_osel, mac1_csel,
   output logic                                  mac1_rnd, mac1_clr, mac1_sat,
   output logic                                  mac1_reset,
   output logic                                  mac1_clken,
   output logic [1:0]                            ram_oper0_rmode, ram_oper0_wmode,
   output logic [1:0]                            ram_oper1_rmode, ram_oper1_wmode,
   output logic [1:0]                            ram_coef_rmode, ram_coef_wmode,
   output logic                                  ram_oper0_wdsel,
   output logic                                  ram_oper1_wdsel,
   output logic                                  ram_coef_wdsel,
   output logic [efpga_harness_pkg::FPGAIO_W-1:0] fpgaio_out,
   output logic [efpga_harness_pkg::FPGAIO_W-1:0] fpgaio_oe,
   output logic [efpga_harness_pkg::EVENTS_W-1:0] events_o
);
   import efpga_harness_pkg::*;

   word_t mac0_ctrl;
   word_t mac1_ctrl;
   word_t ram_ctrl;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         mac0_ctrl  <= '0;
         mac1_ctrl  <= '0;
         ram_ctrl   <= '0;
         fpgaio_out <= '0;
         fpgaio_oe  <= '0;
         events_o   <= '0;
         mac0_clken <= 1'b0;
         mac1_clken <= 1'b0;
      end else begin
         // single-cycle clock enables
         mac0_clken <= wr_en && (bus_addr == ADDR_MAC0_STROBE);
         mac1_clken <= wr_en && (bus_addr == ADDR_MAC1_STROBE);
         if (wr_en) begin
            case (bus_addr)
               ADDR_MAC0_CTRL: mac0_ctrl <= bus_wdata;
               ADDR_MAC1_CTRL: mac1_ctrl <= bus_wdata;
               ADDR_RAM_CTRL:  ram_ctrl  <= bus_wdata;
               ADDR_IO_OUT0:   fpgaio_out[0 +: WORD_W]         <= bus_wdata;
               ADDR_IO_OUT1:   fpgaio_out[WORD_W +: WORD_W]    <= bus_wdata;
               ADDR_IO_OUT2:   fpgaio_out[2*WORD_W +: IO_HI_W] <= bus_wdata[IO_HI_W-1:0];
               ADDR_IO_OE0:    fpgaio_oe[0 +: WORD_W]          <= bus_wdata;
               ADDR_IO_OE1:    fpgaio_oe[WORD_W +: WORD_W]     <= bus_wdata;
               ADDR_IO_OE2:    fpgaio_oe[2*WORD_W +: IO_HI_W]  <= bus_wdata[IO_HI_W-1:0];
               ADDR_EVENTS:    events_o  <= bus_wdata[EVENTS_W-1:0];
               default: ;   // read-only or unmapped
            endcase
         end
      end
   end

   assign mac0_outsel = mac0_ctrl[MAC_OUTSEL_LSB +: 6];
   assign mac0_tc     = mac0_ctrl[MAC_TC_BIT];
   assign mac0_mode   = mac0_ctrl[MAC_MODE_LSB +: 2];
   assign mac0_osel   = mac0_ctrl[MAC_OSEL_BIT];
   assign mac0_csel   = mac0_ctrl[MAC_CSEL_BIT];
   assign mac0_rnd    = mac0_ctrl[MAC_RND_BIT];
   assign mac0_clr    = mac0_ctrl[MAC_CLR_BIT];
   assign mac0_sat    = mac0_ctrl[MAC_SAT_BIT];
   assign mac0_reset  = mac0_ctrl[MAC_RESET_BIT];

   assign mac1_outsel = mac1_ctrl[MAC_OUTSEL_LSB +: 6];
   assign mac1_tc     = mac1_ctrl[MAC_TC_BIT];
   assign mac1_mode   = mac1_ctrl[MAC_MODE_LSB +: 2];
   assign mac1_osel   = mac1_ctrl[MAC_OSEL_BIT];
   assign mac1_csel   = mac1_ctrl[MAC_CSEL_BIT];
   assign mac1_rnd    = mac1_ctrl[MAC_RND_BIT];
   assign mac1_clr    = mac1_ctrl[MAC_CLR_BIT];
   assign mac1_sat    = mac1_ctrl[MAC_SAT_BIT];
   assign mac1_reset  = mac1_ctrl[MAC_RESET_BIT];

   assign ram_oper0_rmode = ram_ctrl[RAM_OPER0_RMODE_LSB +: 2];
   assign ram_oper0_wmode = ram_ctrl[RAM_OPER0_WMODE_LSB +: 2];
   assign ram_oper1_rmode = ram_ctrl[RAM_OPER1_RMODE_LSB +: 2];
   assign ram_oper1_wmode = ram_ctrl[RAM_OPER1_WMODE_LSB +: 2];
   assign ram_coef_rmode  = ram_ctrl[RAM_COEF_RMODE_LSB +: 2];
   assign ram_coef_wmode  = ram_ctrl[RAM_COEF_WMODE_LSB +: 2];
   assign ram_oper0_wdsel = ram_ctrl[RAM_OPER0_WDSEL_BIT];
   assign ram_oper1_wdsel = ram_ctrl[RAM_OPER1_WDSEL_BIT];
   assign ram_coef_wdsel  = ram_ctrl[RAM_COEF_WDSEL_BIT];

   always_comb begin
      reg_rdata = '0;
      reg_hit   = 1'b1;
      case (bus_addr)
         ADDR_MAC0_CTRL: reg_rdata = mac0_ctrl;
         ADDR_MAC1_CTRL: reg_rdata = mac1_ctrl;
         ADDR_RAM_CTRL:  reg_rdata = ram_ctrl;
         ADDR_IO_OUT0:   reg_rdata = fpgaio_out[0 +: WORD_W];
         ADDR_IO_OUT1:   reg_rdata = fpgaio_out[WORD_W +: WORD_W];
         ADDR_IO_OUT2:   reg_rdata = word_t'(fpgaio_out[2*WORD_W +: IO_HI_W]);  // zero-ext
         ADDR_IO_OE0:    reg_rdata = fpgaio_oe[0 +: WORD_W];
         ADDR_IO_OE1:    reg_rdata = fpgaio_oe[WORD_W +: WORD_W];
         ADDR_IO_OE2:    reg_rdata = word_t'(fpgaio_oe[2*WORD_W +: IO_HI_W]);
         ADDR_IO_IN0:    reg_rdata = fpgaio_in[0 +: WORD_W];
         ADDR_IO_IN1:    reg_rdata = fpgaio_in[WORD_W +: WORD_W];
         ADDR_IO_IN2:    reg_rdata = word_t'(fpgaio_in[2*WORD_W +: IO_HI_W]);
         ADDR_EVENTS:    reg_rdata = word_t'(events_o);
         ADDR_MAC0_DOUT: reg_rdata = mac0_dataout;
         ADDR_MAC1_DOUT: reg_rdata = mac1_dataout;
         ADDR_ID:        reg_rdata = ID_CODE;
         default:        reg_hit   = 1'b0;   // RAM window or unmapped
      endcase
   end

endmodule

// File: ram_port_ctrl.sv
module ram_port_ctrl (
   input  logic                          CLK,
   input  logic                          rst_n,
   input  efpga_harness_pkg::lint_addr_t bus_addr,
   input  efpga_harness_pkg::word_t      bus_wdata,
   input  logic                          wr_en,
   input  logic                          rd_start,
   input  efpga_harness_pkg::word_t      ram_oper0_rdata,
   input  efpga_harness_pkg::word_t      ram_oper1_rdata,
   input  efpga_harness_pkg::word_t      ram_coef_rdata,
   output efpga_harness_pkg::ram_addr_t  ram_oper0_waddr, ram_oper0_raddr,
   output efpga_harness_pkg::word_t      ram_oper0_wdata,
   output logic                          ram_oper0_we,
   output efpga_harness_pkg::ram_addr_t  ram_oper1_waddr, ram_oper1_raddr,
   output efpga_harness_pkg::word_t      ram_oper1_wdata,
   output logic                          ram_oper1_we,
   output efpga_harness_pkg::ram_addr_t  ram_coef_waddr, ram_coef_raddr,
   output efpga_harness_pkg::word_t      ram_coef_wdata,
   output logic                          ram_coef_we,
   output efpga_harness_pkg::word_t      ram_rdata,
   output logic                          ram_hit
);
   import efpga_harness_pkg::*;

   ram_sel_e        bus_sel;
   ram_sel_e        rd_sel;    // window of the last read
   ram_addr_t [2:0] waddr_q;   // index 0 oper0, 1 oper1, 2 coef
   ram_addr_t [2:0] raddr_q;
   word_t     [2:0] wdata_q;
   logic      [2:0] we_q;

   always_comb begin
      case (bus_addr[19:12])
         8'h01:   bus_sel = RAM_OPER0;
         8'h02:   bus_sel = RAM_OPER1;
         8'h03:   bus_sel = RAM_COEF;
         default: bus_sel = RAM_NONE;
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         rd_sel  <= RAM_NONE;
         we_q    <= '0;
         waddr_q <= '0;
         raddr_q <= '0;
         wdata_q <= '0;
      end else begin
         we_q <= '0;   // one pulse per write
         if (rd_start) begin
            rd_sel <= bus_sel;
         end
         for (int i = 0; i < 3; i++) begin
            if (bus_sel == ram_sel_e'(i + 1)) begin
               if (wr_en) begin
                  waddr_q[i] <= ram_addr_t'(bus_addr);
                  wdata_q[i] <= bus_wdata;
                  we_q[i]    <= 1'b1;
               end
               if (rd_start) begin
                  raddr_q[i] <= ram_addr_t'(bus_addr);
               end
            end
         end
      end
   end

   assign ram_oper0_waddr = waddr_q[0];
   assign ram_oper0_raddr = raddr_q[0];
   assign ram_oper0_wdata = wdata_q[0];
   assign ram_oper0_we    = we_q[0];
   assign ram_oper1_waddr = waddr_q[1];
   assign ram_oper1_raddr = raddr_q[1];
   assign ram_oper1_wdata = wdata_q[1];
   assign ram_oper1_we    = we_q[1];
   assign ram_coef_waddr  = waddr_q[2];
   assign ram_coef_raddr  = raddr_q[2];
   assign ram_coef_wdata  = wdata_q[2];
   assign ram_coef_we     = we_q[2];

   always_comb begin
      case (rd_sel)
         RAM_OPER0: ram_rdata = ram_oper0_rdata;
         RAM_OPER1: ram_rdata = ram_oper1_rdata;
         RAM_COEF:  ram_rdata = ram_coef_rdata;
         default:   ram_rdata = '0;
      endcase
   end

   assign ram_hit = (rd_sel != RAM_NONE);

endmodule

// File: efpga_harness_top.sv
module efpga_harness_top #(
   parameter efpga_harness_pkg::word_t ID_CODE = 32'hCA11_EF3A
) (
   input  logic                                  CLK,
   input  logic                                  rst_n,
   input  logic                                  lint_req,
   input  logic                                  lint_wen,
   input  efpga_harness_pkg::lint_addr_t         lint_addr,
   input  efpga_harness_pkg::word_t              lint_wdata,
   input  efpga_harness_pkg::be_t                lint_be,   // full-word accesses only
   output logic                                  lint_gnt,
   output logic                                  lint_valid,
   output efpga_harness_pkg::word_t              lint_rdata,
   input  logic [efpga_harness_pkg::FPGAIO_W-1:0] fpgaio_in,
   output logic [efpga_harness_pkg::FPGAIO_W-1:0] fpgaio_out,
   output logic [efpga_harness_pkg::FPGAIO_W-1:0] fpgaio_oe,
   output logic [efpga_harness_pkg::EVENTS_W-1:0] events_o,
   input  efpga_harness_pkg::word_t              mac0_dataout,
   input  efpga_harness_pkg::word_t              mac1_dataout,
   output logic [5:0]                            mac0_outsel, mac1_outsel,
   output logic                                  mac0_tc, mac1_tc,
   output logic [1:0]                            mac0_mode, mac1_mode,
   output logic                                  mac0_osel, mac0_csel,
   output logic                                  mac1_osel, mac1_csel,
   output logic                                  mac0_rnd, mac0_clr, mac0_sat,
   output logic                                  mac1_rnd, mac1_clr, mac1_sat,
   output logic                                  mac0_reset, mac1_reset,
   output logic                                  mac0_clken, mac1_clken,
   output logic [1:0]                            ram_oper0_rmode, ram_oper0_wmode,
   output logic [1:0]                            ram_oper1_rmode, ram_oper1_wmode,
   output logic [1:0]                            ram_coef_rmode, ram_coef_wmode,
   output logic                                  ram_oper0_wdsel,
   output logic                                  ram_oper1_wdsel,
   output logic                                  ram_coef_wdsel,
   input  efpga_harness_pkg::word_t              ram_oper0_rdata,
   input  efpga_harness_pkg::word_t              ram_oper1_rdata,
   input  efpga_harness_pkg::word_t              ram_coef_rdata,
   output efpga_harness_pkg::ram_addr_t          ram_oper0_waddr, ram_oper0_raddr,
   output efpga_harness_pkg::word_t              ram_oper0_wdata,
   output logic                                  ram_oper0_we,
   output efpga_harness_pkg::ram_addr_t          ram_oper1_waddr, ram_oper1_raddr,
   output efpga_harness_pkg::word_t              ram_oper1_wdata,
   output logic                                  ram_oper1_we,
   output efpga_harness_pkg::ram_addr_t          ram_coef_waddr, ram_coef_raddr,
   output efpga_harness_pkg::word_t              ram_coef_wdata,
   output logic                                  ram_coef_we
);
   import efpga_harness_pkg::*;

   lint_addr_t bus_addr;
   word_t      bus_wdata;
   logic       wr_en;
   logic       rd_start;
   word_t      reg_rdata;
   logic       reg_hit;
   word_t      ram_rdata;
   logic       ram_hit;

   lint_slave lint_slave_i (.*);   // bus handshake, read data

   harness_regs #(
      .ID_CODE(ID_CODE)
   ) harness_regs_i (.*);

   ram_port_ctrl ram_port_ctrl_i (.*);   // block RAM ports

endmodule

// File: efpga_harness_asserts.sv
module efpga_harness_asserts (
   input logic                          CLK,
   input logic                          rst_n,
   input logic                          lint_req,
   input logic                          lint_wen,
   input logic                          lint_gnt,
   input logic                          lint_valid,
   input logic                          wr_en,
   input logic                          rd_start,
   input efpga_harness_pkg::lint_addr_t bus_addr,
   input logic                          mac0_clken,
   input logic                          mac1_clken,
   input logic                          ram_oper0_we,
   input logic                          ram_oper1_we,
   input logic                          ram_coef_we
);
   timeunit 1ns;
   timeprecision 1ps;
   import efpga_harness_pkg::*;

   // gnt during the commit cycle, request seen one edge earlier
   write_timing: assert property (@(posedge CLK) disable iff (!rst_n)
      wr_en |-> (lint_gnt && $past(lint_req && !lint_wen)) ##1 lint_valid)
      else $error("write handshake out of order");

   read_timing: assert property (@(posedge CLK) disable iff (!rst_n)
      rd_start |=> !lint_gnt ##1 !lint_gnt ##1 lint_gnt ##1 lint_valid)
      else $error("read handshake out of order");

   valid_single: assert property (@(posedge CLK) disable iff (!rst_n)
      lint_valid |=> !lint_valid)
      else $error("lint_valid held for more than one cycle");

   // granted write on the bus, clken in the cycle after
   mac0_strobe: assert property (@(posedge CLK) disable iff (!rst_n)
      (lint_gnt && !lint_wen && bus_addr == ADDR_MAC0_STROBE)
      |=> (mac0_clken && !mac1_clken) ##1 !mac0_clken)
      else $error("mac0 clock enable pulse wrong");

   mac1_strobe: assert property (@(posedge CLK) disable iff (!rst_n)
      (lint_gnt && !lint_wen && bus_addr == ADDR_MAC1_STROBE)
      |=> (mac1_clken && !mac0_clken) ##1 !mac1_clken)
      else $error("mac1 clock enable pulse wrong");

   ram_we_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
      (ram_oper0_we || ram_oper1_we || ram_coef_we)
      |=> !(ram_oper0_we || ram_oper1_we || ram_coef_we))
      else $error("RAM write enable held for more than one cycle");

endmodule

bind efpga_harness_top efpga_harness_asserts efpga_harness_asserts_i (
   .CLK, .rst_n, .lint_req, .lint_wen, .lint_gnt, .lint_valid, .wr_en, .rd_start,
   .bus_addr, .mac0_clken, .mac1_clken, .ram_oper0_we, .ram_oper1_we, .ram_coef_we
);

// File: tb_efpga_harness.sv
module tb_efpga_harness;
   timeunit 1ns;
   timeprecision 1ps;
   import efpga_harness_pkg::*;

   typedef logic [FPGAIO_W-1:0] vec_t;

   localparam word_t ID_VALUE  = 32'hCA11_EF3A;
   localparam int    NUM_TRANS = 2 * 10 + 2 * 6 + 9;   // registers, RAM windows, read-only
   localparam lint_addr_t REG_ADDR [10] = '{ADDR_MAC0_CTRL, ADDR_MAC1_CTRL, ADDR_RAM_CTRL,
      ADDR_IO_OUT0, ADDR_IO_OUT1, ADDR_IO_OUT2, ADDR_IO_OE0, ADDR_IO_OE1, ADDR_IO_OE2,
      ADDR_EVENTS};
   // top I/O words and events hold 16 bits
   localparam word_t REG_MASK [10] = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
      32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
      32'h0000_FFFF, 32'h0000_FFFF};

   logic        CLK = 1'b0;
   logic        rst_n = 1'b0;
   logic        lint_req = 1'b0;
   logic        lint_wen = 1'b1;
   lint_addr_t  lint_addr = '0;
   word_t       lint_wdata = '0;
   be_t         lint_be = 4'hF;
   logic        lint_gnt, lint_valid;
   word_t       lint_rdata;
   vec_t        fpgaio_in = '0;
   vec_t        fpgaio_out, fpgaio_oe;
   logic [EVENTS_W-1:0] events_o;
   word_t       mac0_dataout = '0;
   word_t       mac1_dataout = '0;
   logic [5:0]  mac0_outsel, mac1_outsel;
   logic [1:0]  mac0_mode, mac1_mode;
   logic        mac0_tc, mac0_osel, mac0_csel, mac0_rnd, mac0_clr, mac0_sat, mac0_reset;
   logic        mac1_tc, mac1_osel, mac1_csel, mac1_rnd, mac1_clr, mac1_sat, mac1_reset;
   logic        mac0_clken, mac1_clken;
   logic [1:0]  ram_oper0_rmode, ram_oper0_wmode, ram_oper1_rmode, ram_oper1_wmode;
   logic [1:0]  ram_coef_rmode, ram_coef_wmode;
   logic        ram_oper0_wdsel, ram_oper1_wdsel, ram_coef_wdsel;
   word_t       ram_oper0_rdata = '0;
   word_t       ram_oper1_rdata = '0;
   word_t       ram_coef_rdata = '0;
   ram_addr_t   ram_oper0_waddr, ram_oper0_raddr, ram_oper1_waddr, ram_oper1_raddr;
   ram_addr_t   ram_coef_waddr, ram_coef_raddr;
   word_t       ram_oper0_wdata, ram_oper1_wdata, ram_coef_wdata;
   logic        ram_oper0_we, ram_oper1_we, ram_coef_we;

   wire [14:0] mac0_fields = {mac0_reset, mac0_sat, mac0_clr, mac0_rnd, mac0_csel, mac0_osel,
                              mac0_mode, mac0_tc, mac0_outsel};
   wire [14:0] mac1_fields = {mac1_reset, mac1_sat, mac1_clr, mac1_rnd, mac1_csel, mac1_osel,
                              mac1_mode, mac1_tc, mac1_outsel};
   wire [14:0] ram_fields  = {ram_coef_wdsel, ram_oper1_wdsel, ram_oper0_wdsel, ram_coef_wmode,
                              ram_coef_rmode, ram_oper1_wmode, ram_oper1_rmode,
                              ram_oper0_wmode, ram_oper0_rmode};

   word_t       oper0_mem [4096];
   word_t       oper1_mem [4096];
   word_t       coef_mem [4096];
   logic [31:0] lfsr = 32'h5f11_9822;
   int          checks = 0;
   int          errors = 0;
   int          test_errors = 0;
   int          tests_run = 0;

   efpga_harness_top #(
      .ID_CODE(ID_VALUE)
   ) efpga_harness_top_i (.*);

   always #5 CLK = ~CLK;

   // block RAMs with one cycle of read latency
   always @(posedge CLK) begin
      if (ram_oper0_we)
         oper0_mem[ram_oper0_waddr] <= ram_oper0_wdata;
      if (ram_oper1_we)
         oper1_mem[ram_oper1_waddr] <= ram_oper1_wdata;
      if (ram_coef_we)
         coef_mem[ram_coef_waddr] <= ram_coef_wdata;
      ram_oper0_rdata <= oper0_mem[ram_oper0_raddr];
      ram_oper1_rdata <= oper1_mem[ram_oper1_raddr];
      ram_coef_rdata  <= coef_mem[ram_coef_raddr];
   end

   function automatic vec_t rand_vec(input int nbits);
      vec_t v;
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         v    = {v[FPGAIO_W-2:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);   // galois taps 32,22,2,1
      end
      return v;
   endfunction

   function automatic logic [14:0] mac_fields(input word_t v);
      return {v[MAC_RESET_BIT], v[MAC_SAT_BIT], v[MAC_CLR_BIT], v[MAC_RND_BIT],
              v[MAC_CSEL_BIT], v[MAC_OSEL_BIT], v[MAC_MODE_LSB +: 2], v[MAC_TC_BIT],
              v[MAC_OUTSEL_LSB +: 6]};
   endfunction

   task automatic check_value(input string name, input vec_t exp, input vec_t act);
      checks++;
      assert (act === exp)
      else begin
         test_errors++;
         $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      errors += test_errors;
      $display("test %s: %0d errors", name, test_errors);
      test_errors = 0;
   endtask

   task automatic lint_access(input logic is_read, input lint_addr_t addr, input word_t data,
                              output word_t rdata);
      int    cycles;
      string name;
      cycles = 0;
      name   = is_read ? "read latency" : "write latency";
      @(posedge CLK);
      lint_req   <= 1'b1;
      lint_wen   <= is_read;
      lint_addr  <= addr;
      lint_wdata <= data;
      @(negedge CLK);
      while (!lint_gnt) begin
         @(negedge CLK);
         cycles++;
      end
      @(posedge CLK);
      lint_req <= 1'b0;   // drop in the gnt cycle
      @(negedge CLK);
      cycles++;
      while (!lint_valid) begin
         @(negedge CLK);
         cycles++;
      end
      rdata = lint_rdata;
      check_value(name, vec_t'(is_read ? 4 : 2), vec_t'(cycles));
   endtask

   task automatic lint_write(input lint_addr_t addr, input word_t data);
      word_t unused_rdata;
      lint_access(1'b0, addr, data, unused_rdata);
   endtask

   task automatic lint_read(input lint_addr_t addr, output word_t data);
      lint_access(1'b1, addr, '0, data);
   endtask

   initial begin
      word_t      vals [10];
      word_t      rd;
      word_t      data;
      lint_addr_t addr;

      repeat (2) @(posedge CLK);
      rst_n        <= 1'b1;
      fpgaio_in    <= rand_vec(FPGAIO_W);
      mac0_dataout <= word_t'(rand_vec(32));
      mac1_dataout <= word_t'(rand_vec(32));
      @(negedge CLK);
      check_value("reset strobes", '0, vec_t'({lint_gnt, lint_valid, mac1_clken, mac0_clken,
                                               ram_coef_we, ram_oper1_we, ram_oper0_we}));
      check_value("reset fields", '0, vec_t'({mac1_fields, mac0_fields, ram_fields}));
      check_value("reset io out", '0, fpgaio_out);
      check_value("reset io oe", '0, vec_t'(fpgaio_oe | vec_t'(events_o)));
      check_value("reset rdata", vec_t'(32'hFFFF_FFFF), vec_t'(lint_rdata));
      end_test("reset_state");

      for (int i = 0; i < 10; i++) begin
         vals[i] = word_t'(rand_vec(32));
         lint_write(REG_ADDR[i], vals[i]);
      end
      for (int i = 0; i < 10; i++) begin
         lint_read(REG_ADDR[i], rd);
         check_value($sformatf("readback %h", REG_ADDR[i]), vec_t'(vals[i] & REG_MASK[i]),
                     vec_t'(rd));
      end
      check_value("mac0 fields", vec_t'(mac_fields(vals[0])), vec_t'(mac0_fields));
      check_value("mac1 fields", vec_t'(mac_fields(vals[1])), vec_t'(mac1_fields));
      check_value("ram fields", vec_t'({vals[2][RAM_COEF_WDSEL_BIT],
         vals[2][RAM_OPER1_WDSEL_BIT], vals[2][RAM_OPER0_WDSEL_BIT],
         vals[2][RAM_COEF_WMODE_LSB +: 2], vals[2][RAM_COEF_RMODE_LSB +: 2],
         vals[2][RAM_OPER1_WMODE_LSB +: 2], vals[2][RAM_OPER1_RMODE_LSB +: 2],
         vals[2][RAM_OPER0_WMODE_LSB +: 2], vals[2][RAM_OPER0_RMODE_LSB +: 2]}),
         vec_t'(ram_fields));
      check_value("fpgaio_out", {vals[5][15:0], vals[4], vals[3]}, fpgaio_out);
      check_value("fpgaio_oe", {vals[8][15:0], vals[7], vals[6]}, fpgaio_oe);
      check_value("events_o", vec_t'(vals[9][15:0]), vec_t'(events_o));
      end_test("register_round_trip");

      for (int w = 1; w <= 3; w++) begin
         for (int n = 0; n < 2; n++) begin
            addr = {8'(w), 12'(rand_vec(12))};
            data = word_t'(rand_vec(32));
            lint_write(addr, data);
            check_value("ram we", vec_t'(3'b001 << (w - 1)),
                        vec_t'({ram_coef_we, ram_oper1_we, ram_oper0_we}));
            check_value("ram waddr", vec_t'(addr[11:0]), vec_t'(ram_addr_t'(
               {ram_coef_waddr, ram_oper1_waddr, ram_oper0_waddr} >> (12 * (w - 1)))));
            check_value("ram wdata", vec_t'(data), vec_t'(word_t'(
               {ram_coef_wdata, ram_oper1_wdata, ram_oper0_wdata} >> (32 * (w - 1)))));
            lint_read(addr, rd);
            check_value("ram raddr", vec_t'(addr[11:0]), vec_t'(ram_addr_t'(
               {ram_coef_raddr, ram_oper1_raddr, ram_oper0_raddr} >> (12 * (w - 1)))));
            check_value($sformatf("ram read %h", addr), vec_t'(data), vec_t'(rd));
         end
      end
      end_test("ram_windows");

      lint_write(ADDR_MAC0_STROBE, word_t'(rand_vec(32)));
      check_value("mac0 strobe", vec_t'(2'b01), vec_t'({mac1_clken, mac0_clken}));
      lint_write(ADDR_MAC1_STROBE, word_t'(rand_vec(32)));
      check_value("mac1 strobe", vec_t'(2'b10), vec_t'({mac1_clken, mac0_clken}));
      lint_read(ADDR_MAC0_DOUT, rd);
      check_value("mac0 dataout", vec_t'(mac0_dataout), vec_t'(rd));
      lint_read(ADDR_MAC1_DOUT, rd);
      check_value("mac1 dataout", vec_t'(mac1_dataout), vec_t'(rd));
      lint_read(ADDR_IO_IN0, rd);
      check_value("fpgaio_in 0", vec_t'(fpgaio_in[31:0]), vec_t'(rd));
      lint_read(ADDR_IO_IN1, rd);
      check_value("fpgaio_in 1", vec_t'(fpgaio_in[63:32]), vec_t'(rd));
      lint_read(ADDR_IO_IN2, rd);
      check_value("fpgaio_in 2", vec_t'(fpgaio_in[79:64]), vec_t'(rd));
      lint_read(ADDR_ID, rd);
      check_value("id word", vec_t'(ID_VALUE), vec_t'(rd));
      lint_read(20'h00FF0, rd);   // nobody claims this one
      check_value("unmapped read", vec_t'(ID_VALUE), vec_t'(rd));
      end_test("strobes_read_only");

      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   initial begin
      #(NUM_TRANS * 6 * 10 * 2);
      $display("watchdog expired before the tests completed");
      $display("tests failed");
      $finish;
   end

endmodule

// File: efpga_harness.f
efpga_harness_pkg.sv
lint_slave.sv
harness_regs.sv
ram_port_ctrl.sv
efpga_harness_top.sv
efpga_harness_asserts.sv
tb_efpga_harness.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the harness testbench
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_efpga_harness -Mdir "$BUILD_DIR" -f efpga_harness.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vtb_efpga_harness" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "tests failed" "$LOG"; then
   echo "simulation FAILED"
   exit 1
fi
echo "simulation PASSED"
exit 0
